//--- Bender.yml
package:
  name: boa_trap_unit

sources:
  - rtl/boa_trap_pkg.sv
  - rtl/boa_csr_file.sv
  - rtl/boa_irq_arbiter.sv
  - rtl/boa_mtimer.sv
  - rtl/boa_trap_ctrl.sv
  - rtl/boa_trap_unit.sv
  - target: test
    files:
      - verif/boa_trap_unit_tb.sv

//--- list.f
rtl/boa_trap_pkg.sv
rtl/boa_csr_file.sv
rtl/boa_irq_arbiter.sv
rtl/boa_mtimer.sv
rtl/boa_trap_ctrl.sv
rtl/boa_trap_unit.sv
verif/boa_trap_unit_tb.sv

//--- rtl/boa_csr_file.sv
// Machine CSR file
`timescale 1ns/1ps

module boa_csr_file import boa_trap_pkg::*; #(
    // Value read back from mhartid.
    parameter xlen_t hartid = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  csr_req_t    csr_req,
    input  trap_event_t trap_event,
    input  logic        mret,
    input  irq_vec_t    pending,
    output csr_rsp_t    csr_rsp,
    output logic        mstatus_mie,
    output irq_vec_t    mie_mask,
    output tvec_t       tvec,
    output pc_t         ret_epc
);

    // Interrupt enable and its saved copy.
    logic   mie_q;
    logic   mpie_q;
    // Per-interrupt enables.
    irq_vec_t mie_q_vec;
    tvec_t  mtvec_q;
    xlen_t  mscratch_q;
    pc_t    mepc_q;
    // Cause split into interrupt flag and number.
    logic   mcause_int_q;
    cause_t mcause_no_q;

    // Composed read views.
    xlen_t mstatus_rd;
    xlen_t mcause_rd;
    xlen_t mip_rd;

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT]  = mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT] = mpie_q;
    end

    assign mcause_rd = {mcause_int_q, 26'd0, mcause_no_q};
    // Only enabled lines show as pending.
    assign mip_rd    = pending & mie_q_vec;

    // Read decode.
    always_comb begin
        csr_rsp.exists = 1'b1;
        csr_rsp.rdonly = 1'b0;
        csr_rsp.rdata  = '0;
        case (csr_req.addr)
            CSR_MSTATUS:    csr_rsp.rdata = mstatus_rd;
            CSR_MISA:       csr_rsp.rdata = MISA_VALUE;
            CSR_MEDELEG:    csr_rsp.rdata = '0;
            CSR_MIDELEG:    csr_rsp.rdata = '0;
            CSR_MIE:        csr_rsp.rdata = mie_q_vec;
            CSR_MTVEC:      csr_rsp.rdata = {mtvec_q, 2'b00};
            CSR_MSTATUSH:   csr_rsp.rdata = '0;
            CSR_MIP:        csr_rsp.rdata = mip_rd;
            CSR_MSCRATCH:   csr_rsp.rdata = mscratch_q;
            CSR_MEPC:       csr_rsp.rdata = {mepc_q, 1'b0};
            CSR_MCAUSE:     csr_rsp.rdata = mcause_rd;
            CSR_MTVAL:      csr_rsp.rdata = '0;
            // Identity registers.
            CSR_MVENDORID,
            CSR_MIPID,
            CSR_MCONFIGPTR: csr_rsp.rdonly = 1'b1;
            CSR_MARCHID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = MARCHID_VALUE;
            end
            CSR_MHARTID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = hartid;
            end
            default:        csr_rsp.exists = 1'b0;
        endcase
    end

    // Reset, then trap entry, then CSR write, then MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q        <= 1'b0;
            mpie_q       <= 1'b0;
            mie_q_vec    <= '0;
            mtvec_q      <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_int_q <= 1'b0;
            mcause_no_q  <= '0;
        end else if (trap_event.irq || trap_event.trap) begin
            // Save enable and disable further interrupts.
            mpie_q       <= mie_q;
            mie_q        <= 1'b0;
            mepc_q       <= trap_event.epc;
            mcause_int_q <= trap_event.irq;
            mcause_no_q  <= trap_event.cause;
        end else if (csr_req.we) begin
            case (csr_req.addr)
                CSR_MSTATUS: begin
                    mie_q  <= csr_req.wdata[MSTATUS_MIE_BIT];
                    mpie_q <= csr_req.wdata[MSTATUS_MPIE_BIT];
                end
                CSR_MIE:      mie_q_vec  <= csr_req.wdata;
                CSR_MTVEC:    mtvec_q    <= csr_req.wdata[31:2];
                CSR_MSCRATCH: mscratch_q <= csr_req.wdata;
                CSR_MEPC:     mepc_q     <= csr_req.wdata[31:1];
                CSR_MCAUSE: begin
                    mcause_int_q <= csr_req.wdata[31];
                    mcause_no_q  <= csr_req.wdata[4:0];
                end
                // Read-only and hardwired registers ignore writes.
                default: ;
            endcase
        end else if (mret) begin
            mie_q <= mpie_q;
        end
    end

    assign mstatus_mie = mie_q;
    assign mie_mask    = mie_q_vec;
    assign tvec        = mtvec_q;
    assign ret_epc     = mepc_q;

    // Dispatch picks one kind of event per cycle.
    assert property (@(posedge clk) disable iff (rst)
        !(trap_event.irq && trap_event.trap))
        else $error("Interrupt and trap dispatched together.");

endmodule

//--- rtl/boa_irq_arbiter.sv
// Interrupt latch and priority
`timescale 1ns/1ps

module boa_irq_arbiter import boa_trap_pkg::*; (
    input  logic     clk,
    input  ext_irq_t irq,
    input  logic     timer_irq,
    input  irq_vec_t mie_mask,
    output irq_vec_t pending,
    output logic     irq_valid,
    output cause_t   irq_cause
);

    // Enabled part of the latched vector.
    irq_vec_t masked;

    // One register stage on every interrupt source.
    always_ff @(posedge clk) begin
        pending             <= '0;
        pending[31:16]      <= irq;
        pending[IRQ_MTIMER] <= timer_irq;
    end

    assign masked    = pending & mie_mask;
    assign irq_valid = |masked;

    // Lowest set bit wins.
    // Scan downward so the last hit is the lowest.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Encoded cause points at an enabled, latched line.
    assert property (@(posedge clk) irq_valid |-> masked[irq_cause])
        else $error("Interrupt cause does not match masked vector.");

endmodule

//--- rtl/boa_mtimer.sv
// Machine timer
`timescale 1ns/1ps

module boa_mtimer import boa_trap_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  timer_req_t timer_req,
    output xlen_t      timer_rdata,
    output logic       timer_irq
);

    // Free-running time in clk cycles.
    xlen_t mtime;
    // Compare value.
    xlen_t mtimecmp;

    // Register selects.
    logic sel_mtime;
    logic sel_mtimecmp;

    assign sel_mtime    = timer_req.addr == TIMER_REG_MTIME;
    assign sel_mtimecmp = timer_req.addr == TIMER_REG_MTIMECMP;

    // A write replaces this cycle's increment.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (timer_req.we && sel_mtime) begin
            mtime <= timer_req.wdata;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // All ones out of reset keeps the interrupt quiet.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (timer_req.we && sel_mtimecmp) begin
            mtimecmp <= timer_req.wdata;
        end
    end

    // Read mux.
    // Unmapped offsets read as zero.
    always_comb begin
        timer_rdata = '0;
        if (timer_req.re) begin
            if (sel_mtime) begin
                timer_rdata = mtime;
            end else if (sel_mtimecmp) begin
                timer_rdata = mtimecmp;
            end
        end
    end

    // Unsigned compare.
    assign timer_irq = mtime >= mtimecmp;

endmodule

//--- rtl/boa_trap_ctrl.sv
// Trap dispatch control
`timescale 1ns/1ps

module boa_trap_ctrl import boa_trap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  retire_t     retire,
    input  logic        mstatus_mie,
    input  logic        irq_valid,
    input  cause_t      irq_cause,
    output trap_event_t trap_event,
    output logic        exception
);

    // Recent history of mstatus.mie, newest in bit 0.
    logic [MIE_SETTLE_DEPTH-1:0] mie_hist;
    // Interrupts allowed this cycle.
    logic irq_en;
    // Each kind of event this cycle.
    logic take_irq;
    logic take_trap;

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= (mie_hist << 1) | MIE_SETTLE_DEPTH'(mstatus_mie);
        end
    end

    // Enable must have held for the full depth and still hold.
    assign irq_en = (&mie_hist) && mstatus_mie;

    // No dispatch while held in reset.
    // An interrupt rides on a retiring instruction.
    assign take_irq  = !rst && irq_en && irq_valid && retire.valid;
    // Interrupt wins over a trap in the same slot.
    assign take_trap = !rst && !take_irq && retire.valid && retire.trap;

    always_comb begin
        trap_event       = '0;
        trap_event.irq   = take_irq;
        trap_event.trap  = take_trap;
        // Return point is the retiring instruction.
        trap_event.epc   = retire.pc;
        if (take_irq) begin
            trap_event.cause = irq_cause;
        end else if (take_trap) begin
            trap_event.cause = {1'b0, retire.cause};
        end
    end

    assign exception = trap_event.irq || trap_event.trap;

    // Nothing is dispatched while the unit is held in reset.
    assert property (@(posedge clk) rst |-> !exception)
        else $error("Exception raised during reset.");

endmodule

//--- rtl/boa_trap_pkg.sv
// Trap unit shared definitions
package boa_trap_pkg;

    // Machine word width.
    localparam int XLEN = 32;

    // Plain machine word.
    typedef logic [XLEN-1:0] xlen_t;
    // Halfword-aligned program counter.
    typedef logic [31:1] pc_t;
    // Word-aligned trap vector base.
    typedef logic [31:2] tvec_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Interrupt or trap number.
    typedef logic [4:0] cause_t;
    // One bit per interrupt number.
    typedef logic [31:0] irq_vec_t;
    // External lines, numbered as their interrupt.
    typedef logic [31:16] ext_irq_t;

    // Machine trap setup.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    // Machine identity, all read-only.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIPID      = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Interrupt enable bits in mstatus.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Machine timer interrupt number.
    localparam cause_t IRQ_MTIMER = 5'd7;

    // RV32 with I and M extensions.
    localparam xlen_t MISA_VALUE    = 32'h4000_1100;
    localparam xlen_t MARCHID_VALUE = 32'd37;

    // Edges mstatus.mie must hold before interrupts are taken.
    localparam int MIE_SETTLE_DEPTH = 2;

    // Timer port byte offsets.
    localparam logic [3:0] TIMER_REG_MTIME    = 4'h0;
    localparam logic [3:0] TIMER_REG_MTIMECMP = 4'h8;

    typedef struct packed {
        csr_addr_t addr;
        logic      we;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic  exists;
        logic  rdonly;
        xlen_t rdata;
    } csr_rsp_t;

    typedef struct packed {
        logic       valid;
        pc_t        pc;
        logic       trap;
        logic [3:0] cause;
    } retire_t;

    typedef struct packed {
        logic   irq;
        logic   trap;
        cause_t cause;
        pc_t    epc;
    } trap_event_t;

    typedef struct packed {
        logic       re;
        logic       we;
        logic [3:0] addr;
        xlen_t      wdata;
    } timer_req_t;

endpackage

//--- rtl/boa_trap_unit.sv
// Machine trap unit
`timescale 1ns/1ps

module boa_trap_unit import boa_trap_pkg::*; #(
    // Value of mhartid.
    parameter xlen_t hartid = '0
) (
    input  logic       clk,
    input  logic       rst,
    input  csr_req_t   csr_req,
    input  retire_t    retire,
    input  logic       mret,
    input  ext_irq_t   irq,
    input  timer_req_t timer_req,
    output csr_rsp_t   csr_rsp,
    output xlen_t      timer_rdata,
    output logic       exception,
    output tvec_t      tvec,
    output pc_t        ret_epc
);

    // Arbiter to CSR file and controller.
    irq_vec_t    pending;
    logic        irq_valid;
    cause_t      irq_cause;
    // CSR file to arbiter and controller.
    irq_vec_t    mie_mask;
    logic        mstatus_mie;
    // Timer to arbiter.
    logic        timer_irq;
    // Controller to CSR file.
    trap_event_t trap_event;

    boa_trap_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .mstatus_mie (mstatus_mie),
        .irq_valid   (irq_valid),
        .irq_cause   (irq_cause),
        .trap_event  (trap_event),
        .exception   (exception)
    );

    boa_csr_file #(
        .hartid (hartid)
    ) u_csr (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .trap_event  (trap_event),
        .mret        (mret),
        .pending     (pending),
        .csr_rsp     (csr_rsp),
        .mstatus_mie (mstatus_mie),
        .mie_mask    (mie_mask),
        .tvec        (tvec),
        .ret_epc     (ret_epc)
    );

    boa_irq_arbiter u_arb (
        .clk       (clk),
        .irq       (irq),
        .timer_irq (timer_irq),
        .mie_mask  (mie_mask),
        .pending   (pending),
        .irq_valid (irq_valid),
        .irq_cause (irq_cause)
    );

    boa_mtimer u_timer (
        .clk         (clk),
        .rst         (rst),
        .timer_req   (timer_req),
        .timer_rdata (timer_rdata),
        .timer_irq   (timer_irq)
    );

endmodule

//--- verif/boa_trap_unit_tb.sv
// Trap unit testbench
`timescale 1ns/1ps

module boa_trap_unit_tb import boa_trap_pkg::*; ();

    logic       clk;
    logic       rst;
    csr_req_t   csr_req;
    retire_t    retire;
    logic       mret;
    ext_irq_t   irq;
    timer_req_t timer_req;
    csr_rsp_t   csr_rsp;
    xlen_t      timer_rdata;
    logic       exception;
    tvec_t      tvec;
    pc_t        ret_epc;

    // Reference model state.
    logic     m_mie;
    logic     m_mpie;
    irq_vec_t m_mie_vec;
    irq_vec_t m_pend;
    tvec_t    m_mtvec;
    pc_t      m_mepc;
    xlen_t    m_mtime;
    xlen_t    m_mtimecmp;
    logic [MIE_SETTLE_DEPTH-1:0] m_hist;
    // Expected dispatch this cycle.
    logic     exp_irq;
    logic     exp_trap;

    boa_trap_unit #(.hartid(32'd5)) u_dut (.*);

    // 20 ns clock.
    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        stop_failed();
    endtask

    // Settled enable, an enabled latched line and a retiring instruction.
    assign exp_irq  = (&m_hist) && m_mie && |(m_pend & m_mie_vec) && retire.valid;
    // Trap only when no interrupt claims the slot.
    assign exp_trap = !exp_irq && retire.valid && retire.trap;

    always @(posedge clk) begin
        // Every source passes one register stage.
        m_pend <= {irq, 8'd0, (m_mtime >= m_mtimecmp), 7'd0};
        if (rst) begin
            m_mie      <= 1'b0;
            m_mpie     <= 1'b0;
            m_mie_vec  <= '0;
            m_mtvec    <= '0;
            m_mepc     <= '0;
            m_hist     <= '0;
            m_mtime    <= '0;
            m_mtimecmp <= '1;
        end else begin
            m_hist  <= {m_hist[MIE_SETTLE_DEPTH-2:0], m_mie};
            m_mtime <= m_mtime + 1;
            // Loaded value replaces the increment.
            if (timer_req.we && timer_req.addr == TIMER_REG_MTIME) begin
                m_mtime <= timer_req.wdata;
            end
            if (timer_req.we && timer_req.addr == TIMER_REG_MTIMECMP) begin
                m_mtimecmp <= timer_req.wdata;
            end
            // Event beats CSR write, which beats MRET.
            if (exp_irq || exp_trap) begin
                m_mpie <= m_mie;
                m_mie  <= 1'b0;
                m_mepc <= retire.pc;
            end else if (csr_req.we) begin
                case (csr_req.addr)
                    CSR_MSTATUS: begin
                        m_mie  <= csr_req.wdata[MSTATUS_MIE_BIT];
                        m_mpie <= csr_req.wdata[MSTATUS_MPIE_BIT];
                    end
                    CSR_MIE:   m_mie_vec <= csr_req.wdata;
                    CSR_MTVEC: m_mtvec   <= csr_req.wdata[31:2];
                    CSR_MEPC:  m_mepc    <= csr_req.wdata[31:1];
                    default: ;
                endcase
            end else if (mret) begin
                m_mie <= m_mpie;
            end
        end
    end

    a_exception: assert property (@(posedge clk) disable iff (rst)
        exception == (exp_irq || exp_trap))
        else report_mismatch("exception does not match the dispatch model");
    a_tvec: assert property (@(posedge clk) disable iff (rst) tvec == m_mtvec)
        else report_mismatch("tvec does not match mtvec");
    a_ret_epc: assert property (@(posedge clk) disable iff (rst) ret_epc == m_mepc)
        else report_mismatch("ret_epc does not match mepc");
    a_reset: assert property (@(posedge clk) rst |-> !exception)
        else report_mismatch("exception raised during reset");

    task automatic csr_write(input csr_addr_t addr, input xlen_t data);
        @(posedge clk);
        csr_req <= '{addr: addr, we: 1'b1, wdata: data};
        @(posedge clk);
        csr_req.we <= 1'b0;
    endtask

    // Read at mid-cycle, where the response is stable.
    task automatic check_csr(input csr_addr_t addr, input xlen_t data, input logic rdonly);
        @(posedge clk);
        csr_req <= '{addr: addr, we: 1'b0, wdata: '0};
        @(negedge clk);
        assert (csr_rsp.exists && csr_rsp.rdonly == rdonly && csr_rsp.rdata == data)
            else report_mismatch($sformatf("CSR %03h read %08h, expected %08h",
                addr, csr_rsp.rdata, data));
    endtask

    task automatic timer_write(input logic [3:0] addr, input xlen_t data);
        @(posedge clk);
        timer_req <= '{re: 1'b0, we: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        timer_req.we <= 1'b0;
    endtask

    task automatic timer_read(input logic [3:0] addr, output xlen_t data);
        @(posedge clk);
        timer_req <= '{re: 1'b1, we: 1'b0, addr: addr, wdata: '0};
        @(negedge clk);
        data = timer_rdata;
    endtask

    // Returns at the negedge where exception is seen.
    task automatic wait_exception(input string what);
        int n;
        for (n = 0; n < 200; n++) begin
            @(negedge clk);
            if (exception) break;
        end
        if (n == 200) begin
            $display("Timed out after 200 cycles waiting for the %s", what);
            stop_failed();
        end
    endtask

    initial begin
        xlen_t      val;
        xlen_t      t0;
        xlen_t      t1;
        pc_t        pc;
        logic [3:0] cause;
        void'($urandom(53));
        clk       = 1'b0;
        rst       = 1'b1;
        csr_req   = '0;
        // A trapping retire held through reset must stay quiet.
        retire    = '{valid: 1'b1, pc: '0, trap: 1'b1, cause: '0};
        mret      = 1'b0;
        irq       = '0;
        timer_req = '0;
        repeat (16) @(posedge clk);
        rst    <= 1'b0;
        retire <= '0;

        // CSR readback with write masks.
        val = $urandom();
        csr_write(CSR_MSCRATCH, val);
        check_csr(CSR_MSCRATCH, val, 1'b0);
        val = $urandom();
        csr_write(CSR_MTVEC, val);
        check_csr(CSR_MTVEC, val & ~32'h3, 1'b0);
        val = $urandom();
        csr_write(CSR_MEPC, val);
        check_csr(CSR_MEPC, val & ~32'h1, 1'b0);
        val = $urandom();
        csr_write(CSR_MIE, val);
        check_csr(CSR_MIE, val, 1'b0);
        // Identity and ISA registers.
        check_csr(CSR_MISA, MISA_VALUE, 1'b0);
        check_csr(CSR_MVENDORID, '0, 1'b1);
        check_csr(CSR_MARCHID, MARCHID_VALUE, 1'b1);
        check_csr(CSR_MIPID, '0, 1'b1);
        check_csr(CSR_MHARTID, 32'd5, 1'b1);
        check_csr(CSR_MCONFIGPTR, '0, 1'b1);
        @(posedge clk);
        csr_req <= '{addr: 12'h7c0, we: 1'b0, wdata: '0};
        @(negedge clk);
        assert (!csr_rsp.exists) else report_mismatch("unmapped CSR reported as present");

        // Synchronous trap on one retire.
        csr_write(CSR_MSTATUS, 32'h8);
        pc    = pc_t'($urandom());
        cause = 4'($urandom_range(15, 0));
        @(posedge clk);
        retire <= '{valid: 1'b1, pc: pc, trap: 1'b1, cause: cause};
        @(negedge clk);
        assert (exception) else report_mismatch("trap retire did not raise exception");
        @(posedge clk);
        retire <= '0;
        check_csr(CSR_MCAUSE, {28'd0, cause}, 1'b0);
        check_csr(CSR_MEPC, {pc, 1'b0}, 1'b0);
        // Enable saved in mpie and cleared.
        check_csr(CSR_MSTATUS, 32'h80, 1'b0);

        // MRET brings the enable back.
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        check_csr(CSR_MSTATUS, 32'h88, 1'b0);

        // Lines 18 and 21 enabled, 25 left masked.
        csr_write(CSR_MIE, 32'h0024_0000);
        csr_write(CSR_MSTATUS, 32'h8);
        @(posedge clk);
        irq[25] <= 1'b1;
        retire  <= '{valid: 1'b1, pc: pc_t'($urandom()), trap: 1'b0, cause: '0};
        repeat (20) @(posedge clk);
        irq[18] <= 1'b1;
        irq[21] <= 1'b1;
        wait_exception("external interrupt");
        @(posedge clk);
        retire <= '0;
        check_csr(CSR_MCAUSE, 32'h8000_0012, 1'b0);
        check_csr(CSR_MIP, 32'h0024_0000, 1'b0);
        @(posedge clk);
        irq <= '0;

        // Timer runs and fires past the compare value.
        timer_read(TIMER_REG_MTIME, t0);
        repeat (3) @(posedge clk);
        timer_read(TIMER_REG_MTIME, t1);
        assert (t1 > t0) else report_mismatch("mtime did not increase between reads");
        csr_write(CSR_MIE, 32'h80);
        timer_write(TIMER_REG_MTIMECMP, t1 + 32'd20);
        csr_write(CSR_MSTATUS, 32'h8);
        @(posedge clk);
        retire <= '{valid: 1'b1, pc: pc_t'($urandom()), trap: 1'b0, cause: '0};
        wait_exception("timer interrupt");
        @(posedge clk);
        retire <= '0;
        check_csr(CSR_MCAUSE, 32'h8000_0007, 1'b0);

        repeat (4) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule
